// ==== audio_pkg.sv ====
/*
 * Shared types and constants for the stereo audio mixer.
 * Covers sample and wide sum widths, attenuation and crossfeed mode
 * encodings and the default depth of the core glitch filter.
 * Modules import it in their body and use scoped names in port lists.
 */
`default_nettype none

package audio_pkg;

	////////////////////
	// Widths

	localparam int SAMPLE_W = 16;
	// One guard bit above a sample
	localparam int WIDE_W   = SAMPLE_W + 1;
	localparam int ATT_W    = 5;
	localparam int MIX_W    = 2;

	////////////////////
	// Types

	// Core, host or output sample, read as signed unless noted
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	// Intermediate sum of two samples
	typedef logic signed [WIDE_W-1:0]   wide_t;
	// Top bit mutes, low bits give the right shift
	typedef logic [ATT_W-1:0]           att_t;
	typedef logic [MIX_W-1:0]           mix_t;

	////////////////////
	// Encodings

	localparam int ATT_MUTE_BIT = ATT_W - 1;

	// Crossfeed modes
	localparam mix_t MIX_NONE   = 2'd0;
	// Own less 1/8, plus 1/4 of the other pre-mix
	localparam mix_t MIX_LIGHT  = 2'd1;
	// Own less 1/4, plus 1/2 of the other pre-mix
	localparam mix_t MIX_MEDIUM = 2'd2;
	// Half of own plus the whole other pre-mix
	localparam mix_t MIX_FULL   = 2'd3;

	// Identical core samples needed before a new value is taken
	localparam int STAB_DEPTH_DEF = 2;

endpackage

`default_nettype wire

// ==== audio_chan_sum.sv ====
/*
 * Per-channel front end of the stereo mixer.
 * Filters glitches on the core sample, converts unsigned core audio
 * to signed and adds the host PCM sample. Drives the full sum and
 * its half, both registered, into the crossmix stage.
 */
`timescale 1ns/1ps
`default_nettype none

module audio_chan_sum #(
	parameter int STAB_DEPTH = audio_pkg::STAB_DEPTH_DEF
) (
	input  wire logic              clk,
	input  wire logic              resetd,

	input  wire audio_pkg::sample_t i_core,
	input  wire audio_pkg::sample_t i_host,
	input  wire logic              i_is_signed,

	output audio_pkg::wide_t       o_sum,
	output audio_pkg::sample_t     o_pre
);

	import audio_pkg::*;

	// Entry 0 holds the newest core sample
	sample_t hist [0:STAB_DEPTH];
	logic    hist_agree;
	sample_t held;

	wide_t   conv;
	wide_t   host_w;
	wide_t   sum_next;

	////////////////////
	// Glitch filter

	always_ff @(posedge clk) begin
		if (resetd) begin
			for (int i = 0; i <= STAB_DEPTH; i++) begin
				hist[i] <= '0;
			end
		end else begin
			hist[0] <= i_core;
			for (int i = 1; i <= STAB_DEPTH; i++) begin
				hist[i] <= hist[i-1];
			end
		end
	end

	// The oldest STAB_DEPTH entries must all match
	always_comb begin
		hist_agree = 1'b1;
		for (int i = 1; i < STAB_DEPTH; i++) begin
			if (hist[i] != hist[STAB_DEPTH]) begin
				hist_agree = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			held <= '0;
		end else if (hist_agree) begin
			held <= hist[STAB_DEPTH];
		end
	end

	////////////////////
	// Conversion and sum

	// Unsigned core audio is halved so it fits the signed range
	always_ff @(posedge clk) begin
		if (resetd) begin
			conv <= '0;
		end else if (i_is_signed) begin
			conv <= {held[SAMPLE_W-1], held};
		end else begin
			conv <= {2'b00, held[SAMPLE_W-1:1]};
		end
	end

	assign host_w   = {i_host[SAMPLE_W-1], i_host};
	assign sum_next = conv + host_w;

	// Half of the sum feeds the other channel's crossfeed
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sum <= '0;
			o_pre <= '0;
		end else begin
			o_sum <= sum_next;
			o_pre <= sum_next[WIDE_W-1:1];
		end
	end

	////////////////////
	// Checks

	// A new held value only comes from an agreeing history
	for (genvar g = 1; g < STAB_DEPTH; g++) begin : gen_stable_check
		held_from_stable_history: assert property (
			@(posedge clk) disable iff (resetd)
			(!$past(resetd) && (held != $past(held)))
				|-> ($past(hist[g]) == $past(hist[STAB_DEPTH]))
		) else $error("held core sample changed without a stable history");
	end

endmodule

`default_nettype wire

// ==== audio_crossmix.sv ====
/*
 * Crossfeed, attenuation and clamp for both mixer channels.
 * Each output mixes its own sum with the opposite channel's pre-mix,
 * then mutes or shifts it and saturates back to 16 bits.
 * Three register stages give a fixed latency of three cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module audio_crossmix (
	input  wire logic              clk,
	input  wire logic              resetd,

	input  wire audio_pkg::wide_t   i_sum_l,
	input  wire audio_pkg::wide_t   i_sum_r,
	input  wire audio_pkg::sample_t i_pre_l,
	input  wire audio_pkg::sample_t i_pre_r,

	input  wire audio_pkg::mix_t    i_mix,
	input  wire audio_pkg::att_t    i_att,

	output audio_pkg::sample_t     o_out_l,
	output audio_pkg::sample_t     o_out_r
);

	import audio_pkg::*;

	wide_t mix_l;
	wide_t mix_r;
	wide_t att_l;
	wide_t att_r;

	////////////////////
	// Per-sample math

	// Sums stay within 17 bits for every mode
	function automatic wide_t crossfeed(
		input wide_t   own,
		input sample_t other,
		input mix_t    mode
	);
		wide_t oth_w;
		wide_t res;

		oth_w = other;
		case (mode)
			MIX_NONE:   res = own;
			MIX_LIGHT:  res = own - (own >>> 3) + (oth_w >>> 2);
			MIX_MEDIUM: res = own - (own >>> 2) + (oth_w >>> 1);
			MIX_FULL:   res = (own >>> 1) + oth_w;
			default:    res = own;
		endcase
		return res;
	endfunction

	function automatic wide_t attenuate(
		input wide_t din,
		input att_t  att
	);
		wide_t res;

		if (att[ATT_MUTE_BIT]) begin
			res = '0;
		end else begin
			res = din >>> att[ATT_MUTE_BIT-1:0];
		end
		return res;
	endfunction

	// Guard bit differing from the sign bit means overflow
	function automatic sample_t clamp(input wide_t din);
		sample_t res;

		if (din[WIDE_W-1] != din[WIDE_W-2]) begin
			res = {din[WIDE_W-1], {(SAMPLE_W-1){~din[WIDE_W-1]}}};
		end else begin
			res = din[SAMPLE_W-1:0];
		end
		return res;
	endfunction

	////////////////////
	// Pipeline

	// Each side takes the opposite pre-mix
	always_ff @(posedge clk) begin
		if (resetd) begin
			mix_l <= '0;
			mix_r <= '0;
		end else begin
			mix_l <= crossfeed(i_sum_l, i_pre_r, i_mix);
			mix_r <= crossfeed(i_sum_r, i_pre_l, i_mix);
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			att_l <= '0;
			att_r <= '0;
		end else begin
			att_l <= attenuate(mix_l, i_att);
			att_r <= attenuate(mix_r, i_att);
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_out_l <= '0;
			o_out_r <= '0;
		end else begin
			o_out_l <= clamp(att_l);
			o_out_r <= clamp(att_r);
		end
	end

	////////////////////
	// Checks

	// Mute reaches both outputs through the attenuation and clamp stages
	mute_zeroes_outputs: assert property (
		@(posedge clk) disable iff (resetd)
		$past(i_att[ATT_MUTE_BIT], 2) |-> ((o_out_l == '0) && (o_out_r == '0))
	) else $error("muted input did not give silent outputs");

endmodule

`default_nettype wire

// ==== audio_mixer_top.sv ====
/*
 * Top level of the standalone stereo audio mixer.
 * Two channel front ends feed one crossmix stage.
 * Core to output latency is nine cycles with the default filter depth.
 */
`timescale 1ns/1ps
`default_nettype none

module audio_mixer_top #(
	parameter int STAB_DEPTH = audio_pkg::STAB_DEPTH_DEF
) (
	input  wire logic              clk,
	input  wire logic              resetd,

	// Core and host samples per channel
	input  wire audio_pkg::sample_t i_core_l,
	input  wire audio_pkg::sample_t i_core_r,
	input  wire audio_pkg::sample_t i_host_l,
	input  wire audio_pkg::sample_t i_host_r,

	// Static controls
	input  wire logic              i_is_signed,
	input  wire audio_pkg::mix_t    i_mix,
	input  wire audio_pkg::att_t    i_att,

	output audio_pkg::sample_t     o_out_l,
	output audio_pkg::sample_t     o_out_r
);

	import audio_pkg::*;

	wide_t   sum_l;
	wide_t   sum_r;
	sample_t pre_l;
	sample_t pre_r;

	////////////////////
	// Channel front ends

	audio_chan_sum #(
		.STAB_DEPTH  (STAB_DEPTH)
	) chan_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (i_core_l),
		.i_host      (i_host_l),
		.i_is_signed (i_is_signed),
		.o_sum       (sum_l),
		.o_pre       (pre_l)
	);

	audio_chan_sum #(
		.STAB_DEPTH  (STAB_DEPTH)
	) chan_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (i_core_r),
		.i_host      (i_host_r),
		.i_is_signed (i_is_signed),
		.o_sum       (sum_r),
		.o_pre       (pre_r)
	);

	////////////////////
	// Crossfeed and output

	audio_crossmix crossmix (
		.clk     (clk),
		.resetd  (resetd),
		.i_sum_l (sum_l),
		.i_sum_r (sum_r),
		.i_pre_l (pre_l),
		.i_pre_r (pre_r),
		.i_mix   (i_mix),
		.i_att   (i_att),
		.o_out_l (o_out_l),
		.o_out_r (o_out_r)
	);

endmodule

`default_nettype wire

// ==== tb_audio_mixer.sv ====
/*
 * Directed testbench for the standalone stereo audio mixer.
 * Drives both channels, lets the pipeline settle and compares the
 * outputs with a behavioral model of the mixing rules.
 * Run from the project root with the file list sim.f.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_audio_mixer;

	localparam int CLK_HALF      = 20;
	localparam int CLK_PERIOD    = 2 * CLK_HALF;
	localparam int SETTLE_CYCLES = 12;
	localparam int RAND_PAIRS    = 8;

	logic        clk;
	logic        resetd;
	logic [15:0] core_l;
	logic [15:0] core_r;
	logic [15:0] host_l;
	logic [15:0] host_r;
	logic        is_signed;
	logic [1:0]  mix;
	logic [4:0]  att;
	wire  [15:0] out_l;
	wire  [15:0] out_r;

	logic [31:0] lfsr_state;
	int          checks;
	int          errors;
	int          timeouts;

	// Random cores kept for reuse in the unsigned test
	logic [15:0] saved_core_l [0:RAND_PAIRS-1];
	logic [15:0] saved_core_r [0:RAND_PAIRS-1];

	audio_mixer_top audio_mixer_top_inst (
		.clk         (clk),
		.resetd      (resetd),
		.i_core_l    (core_l),
		.i_core_r    (core_r),
		.i_host_l    (host_l),
		.i_host_r    (host_r),
		.i_is_signed (is_signed),
		.i_mix       (mix),
		.i_att       (att),
		.o_out_l     (out_l),
		.o_out_r     (out_r)
	);

	always #(CLK_HALF) clk = ~clk;

	////////////////////
	// Random numbers

	function automatic logic lfsr_bit();
		logic lsb;

		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 32'h80200003;
		end
		return lsb;
	endfunction

	function automatic logic [15:0] rand_word();
		logic [15:0] w;

		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], lfsr_bit()};
		end
		return w;
	endfunction

	////////////////////
	// Reference model

	// Core converted by signedness, plus the signed host sample
	function automatic int chan_sum(input logic [15:0] core, input logic [15:0] host,
			input logic s);
		int c;
		int h;

		if (s) begin
			c = int'($signed(core));
		end else begin
			c = int'({16'd0, core}) >> 1;
		end
		h = int'($signed(host));
		return c + h;
	endfunction

	function automatic logic [15:0] model_out(input logic [15:0] own_core,
			input logic [15:0] own_host, input logic [15:0] oth_core,
			input logic [15:0] oth_host, input logic s, input logic [1:0] m,
			input logic [4:0] a);
		int own;
		int other;
		int mixed;
		int res;

		own   = chan_sum(own_core, own_host, s);
		other = chan_sum(oth_core, oth_host, s) >>> 1;
		case (m)
			2'd1:    mixed = own - (own >>> 3) + (other >>> 2);
			2'd2:    mixed = own - (own >>> 2) + (other >>> 1);
			2'd3:    mixed = (own >>> 1) + other;
			default: mixed = own;
		endcase
		if (a[4]) begin
			res = 0;
		end else begin
			res = mixed >>> a[3:0];
		end
		if (res > 32767) begin
			res = 32767;
		end else if (res < -32768) begin
			res = -32768;
		end
		return 16'(res);
	endfunction

	////////////////////
	// Drive and check

	task automatic drive_inputs(input logic [15:0] cl, input logic [15:0] cr,
			input logic [15:0] hl, input logic [15:0] hr, input logic s,
			input logic [1:0] m, input logic [4:0] a);
		@(posedge clk);
		core_l    <= cl;
		core_r    <= cr;
		host_l    <= hl;
		host_r    <= hr;
		is_signed <= s;
		mix       <= m;
		att       <= a;
	endtask

	// Count clock edges, then move to the falling edge where outputs are stable
	task automatic settle(input int cycles, output logic done);
		int  count;
		time start;
		time limit;

		count = 0;
		start = $time;
		limit = time'((cycles + 2) * CLK_PERIOD);
		while ((count < cycles) && (($time - start) <= limit)) begin
			@(posedge clk);
			count++;
		end
		@(negedge clk);
		done = (count >= cycles);
		if (!done) begin
			timeouts++;
			$display("Timed out after %0d of %0d cycles waiting for the outputs to settle",
				count, cycles);
		end
	endtask

	task automatic check_outputs(input logic [15:0] exp_l, input logic [15:0] exp_r,
			input string label);
		checks++;
		if (out_l !== exp_l) begin
			errors++;
			$display("Error at time %0t: %s left output %0d, expected %0d",
				$time, label, $signed(out_l), $signed(exp_l));
		end
		if (out_r !== exp_r) begin
			errors++;
			$display("Error at time %0t: %s right output %0d, expected %0d",
				$time, label, $signed(out_r), $signed(exp_r));
		end
	endtask

	// Outputs must hold their value on every falling edge of the window
	task automatic hold_steady(input logic [15:0] exp_l, input logic [15:0] exp_r,
			input int cycles, input string label);
		int  count;
		time start;
		time limit;

		count = 0;
		start = $time;
		limit = time'((cycles + 2) * CLK_PERIOD);
		while ((count < cycles) && (($time - start) <= limit)) begin
			@(negedge clk);
			check_outputs(exp_l, exp_r, label);
			count++;
		end
		if (count < cycles) begin
			timeouts++;
			$display("Timed out after %0d of %0d cycles watching the outputs hold",
				count, cycles);
		end
	endtask

	task automatic run_case(input logic [15:0] cl, input logic [15:0] cr,
			input logic [15:0] hl, input logic [15:0] hr, input logic s,
			input logic [1:0] m, input logic [4:0] a, input string label);
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		logic        done;

		exp_l = model_out(cl, hl, cr, hr, s, m, a);
		exp_r = model_out(cr, hr, cl, hl, s, m, a);
		drive_inputs(cl, cr, hl, hr, s, m, a);
		settle(SETTLE_CYCLES, done);
		if (done) begin
			check_outputs(exp_l, exp_r, label);
		end
	endtask

	////////////////////
	// Directed tests

	task automatic reset_zero_check();
		@(negedge clk);
		check_outputs(16'd0, 16'd0, "right after reset");
		run_case(16'd0, 16'd0, 16'd0, 16'd0, 1'b0, 2'd0, 5'd0, "zero inputs");
	endtask

	task automatic signed_passthrough();
		for (int i = 0; i < RAND_PAIRS; i++) begin
			saved_core_l[i] = rand_word();
			saved_core_r[i] = rand_word();
			run_case(saved_core_l[i], saved_core_r[i], rand_word(), rand_word(),
				1'b1, 2'd0, 5'd0, $sformatf("signed pair %0d", i));
		end
	endtask

	task automatic unsigned_conversion();
		for (int i = 0; i < RAND_PAIRS; i++) begin
			run_case(saved_core_l[i], saved_core_r[i], rand_word(), rand_word(),
				1'b0, 2'd0, 5'd0, $sformatf("unsigned pair %0d", i));
		end
	endtask

	task automatic crossfeed_modes();
		for (int m = 1; m <= 3; m++) begin
			// Only the left side is driven, so the right output is pure crossfeed
			run_case(16'sd8000, 16'd0, 16'sd1200, 16'd0, 1'b1, 2'(m), 5'd0,
				$sformatf("mode %0d left only", m));
			for (int i = 0; i < 3; i++) begin
				run_case(rand_word(), rand_word(), rand_word(), rand_word(),
					1'b1, 2'(m), 5'd0, $sformatf("mode %0d random %0d", m, i));
			end
		end
	endtask

	task automatic attenuation_mute();
		logic [4:0] shifts [0:2];
		logic [4:0] mutes  [0:2];

		shifts = '{5'd0, 5'd3, 5'd15};
		mutes  = '{5'h10, 5'h13, 5'h1f};
		for (int i = 0; i < 3; i++) begin
			run_case(-16'sd12345, 16'sd20000, 16'sd3000, 16'sd10000, 1'b1, 2'd2,
				shifts[i], $sformatf("shift %0d", shifts[i]));
		end
		for (int i = 0; i < 3; i++) begin
			run_case(16'sd30000, -16'sd25000, 16'sd1000, -16'sd700, 1'b1, 2'd1,
				mutes[i], $sformatf("mute att 0x%0h", mutes[i]));
		end
	endtask

	task automatic clamp_and_glitch();
		logic [15:0] exp_l;
		logic [15:0] exp_r;

		run_case(16'h7fff, 16'h8000, 16'h7fff, 16'h8000, 1'b1, 2'd0, 5'd0,
			"full scale saturation");
		exp_l = model_out(16'sd5000, 16'sd100, -16'sd4000, 16'sd200, 1'b1, 2'd1, 5'd1);
		exp_r = model_out(-16'sd4000, 16'sd200, 16'sd5000, 16'sd100, 1'b1, 2'd1, 5'd1);
		run_case(16'sd5000, -16'sd4000, 16'sd100, 16'sd200, 1'b1, 2'd1, 5'd1,
			"before glitch");
		// One cycle spike on both cores, then back to the steady value
		@(posedge clk);
		core_l <= 16'h7abc;
		core_r <= 16'h8123;
		@(posedge clk);
		core_l <= 16'sd5000;
		core_r <= -16'sd4000;
		hold_steady(exp_l, exp_r, SETTLE_CYCLES, "after one cycle glitch");
	endtask

	////////////////////
	// Main sequence

	initial begin
		clk        = 1'b0;
		resetd     = 1'b1;
		core_l     = '0;
		core_r     = '0;
		host_l     = '0;
		host_r     = '0;
		is_signed  = 1'b0;
		mix        = '0;
		att        = '0;
		lfsr_state = 32'h93b577c8;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;

		repeat (8) @(posedge clk);
		resetd <= 1'b0;

		reset_zero_check();
		signed_passthrough();
		unsigned_conversion();
		crossfeed_modes();
		attenuation_mute();
		clamp_and_glitch();

		$display("Checks run: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if ((errors == 0) && (timeouts == 0)) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
audio_pkg.sv
audio_chan_sum.sv
audio_crossmix.sv
audio_mixer_top.sv
tb_audio_mixer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the stereo audio mixer testbench with Verilator and run it.
# The result is taken from the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_audio_mixer
BUILD_DIR=obj_dir
BIN=sim_bin
LOG=sim.log

rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" \
	-o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if [ ! -f "$LOG" ]; then
	echo "Simulation log $LOG is missing"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
